// ==== bus_pkg.sv ====
package bus_pkg;

// byte address on either bus, word aligned in this core
typedef logic [31:0] phys_addr_t;

// data word carried by either bus
typedef logic [31:0] bus_word_t;

endpackage

// ==== cpu_bus_if.sv ====
interface cpu_ibus_if;
	logic                read;
	bus_pkg::phys_addr_t address;
	bus_pkg::bus_word_t  rddata;
	logic                stall;

	modport master (
		output read, address,
		input  rddata, stall
	);

	modport slave (
		input  read, address,
		output rddata, stall
	);
endinterface

interface cpu_dbus_if;
	logic                read;
	logic                write;
	bus_pkg::phys_addr_t address;
	bus_pkg::bus_word_t  wrdata;
	bus_pkg::bus_word_t  rddata;
	logic                stall;

	modport master (
		output read, write, address, wrdata,
		input  rddata, stall
	);

	modport slave (
		input  read, write, address, wrdata,
		output rddata, stall
	);
endinterface

// ==== cpu_core.sv ====
module cpu_core #(
	parameter bus_pkg::phys_addr_t RESET_PC  = '0,
	parameter int                  MUL_STEPS = 8
) (
	input  logic       clk,
	input  logic       rst,
	cpu_ibus_if.master ibus,
	cpu_dbus_if.master dbus
);

// flush and stall
logic             freeze, stall_id, load_use, mul_stall, mul_start;
logic             branch_taken;
cpu_pkg::uint32_t branch_target;

// fetch
bus_pkg::phys_addr_t pc_q;
cpu_pkg::uint32_t    if_pc_q;
logic                if_valid_q, id_fresh_q;
cpu_pkg::uint32_t    instr, instr_q;

// pipeline data
cpu_pkg::decoded_t  id_decoded, id_ex_q;
cpu_pkg::exec_t     ex_result, ex_mem_q, wb_result;
logic               adv_q, dbus_done_q;
bus_pkg::bus_word_t load_data, load_data_q;

cpu_pkg::reg_addr_t [1:0] reg_raddr;
cpu_pkg::uint32_t   [1:0] reg_rdata;
cpu_pkg::uint64_t         hilo;

assign freeze   = ibus.stall | dbus.stall | mul_stall;
assign stall_id = freeze | load_use;

assign ibus.read    = ~rst;
assign ibus.address = pc_q;

always_ff @(posedge clk) begin
	if (rst) begin
		pc_q       <= RESET_PC;
		if_valid_q <= 1'b0;
		id_fresh_q <= 1'b0;
	end else begin
		id_fresh_q <= ~stall_id;
		if (~stall_id) begin
			pc_q       <= branch_taken ? branch_target : pc_q + 32'd4;
			// the fetch behind the delay slot is on the wrong path
			if_valid_q <= ~branch_taken;
		end
	end
end

always_ff @(posedge clk) begin
	if (~stall_id)
		if_pc_q <= pc_q;
end

// rddata is only good in the cycle after the fetch was taken
assign instr = id_fresh_q ? ibus.rddata : instr_q;

always_ff @(posedge clk) begin
	instr_q <= instr;
end

regfile regfile_inst (
	.clk,
	.rst,
	.raddr_i ( reg_raddr                 ),
	.rdata_o ( reg_rdata                 ),
	.we_i    ( wb_result.valid & ~freeze ),
	.waddr_i ( wb_result.rd              ),
	.wdata_i ( wb_result.wdata           )
);

instr_decode decode_inst (
	.instr_i     ( instr      ),
	.pc_i        ( if_pc_q    ),
	.valid_i     ( if_valid_q ),
	.reg_raddr_o ( reg_raddr  ),
	.reg_rdata_i ( reg_rdata  ),
	.fwd_exec_i  ( ex_result  ),
	.fwd_wb_i    ( wb_result  ),
	.decoded_o   ( id_decoded ),
	.load_use_o  ( load_use   )
);

// pipeline between ID and EX
always_ff @(posedge clk) begin
	if (rst || (stall_id && ~freeze)) begin
		id_ex_q <= '0;
	end else if (~freeze) begin
		id_ex_q <= id_decoded;
	end
end

// high in the first cycle an instruction spends in EX and in MEM
always_ff @(posedge clk) begin
	if (rst)
		adv_q <= 1'b0;
	else
		adv_q <= ~freeze;
end

assign mul_start = adv_q & id_ex_q.valid & (id_ex_q.op == cpu_pkg::OP_MULTU);

multi_cycle_exec #(
	.MUL_STEPS ( MUL_STEPS )
) multi_cycle_exec_inst (
	.clk,
	.rst,
	.start_i ( mul_start ),
	.a_i     ( id_ex_q.a ),
	.b_i     ( id_ex_q.b ),
	.stall_o ( mul_stall ),
	.hilo_o  ( hilo      )
);

instr_exec exec_inst (
	.data_i          ( id_ex_q       ),
	.hilo_i          ( hilo          ),
	.result_o        ( ex_result     ),
	.branch_taken_o  ( branch_taken  ),
	.branch_target_o ( branch_target )
);

// a store taken while the core is held must not go out twice
always_ff @(posedge clk) begin
	if (rst || ~freeze)
		dbus_done_q <= 1'b0;
	else if (dbus.write && ~dbus.stall)
		dbus_done_q <= 1'b1;
end

assign dbus.read    = id_ex_q.valid & id_ex_q.is_load;
assign dbus.write   = id_ex_q.valid & id_ex_q.is_store & ~dbus_done_q;
assign dbus.address = ex_result.addr;
assign dbus.wrdata  = ex_result.sdata;

// pipeline between EX and MEM
always_ff @(posedge clk) begin
	if (rst)
		ex_mem_q <= '0;
	else if (~freeze)
		ex_mem_q <= ex_result;
end

assign load_data = adv_q ? dbus.rddata : load_data_q;

always_ff @(posedge clk) begin
	load_data_q <= load_data;
end

always_comb begin
	wb_result = ex_mem_q;
	if (ex_mem_q.is_load)
		wb_result.wdata = load_data;
end

a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
	!(dbus.read && dbus.write));

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [63:0] uint64_t;
typedef logic [4:0]  reg_addr_t;

// primary opcode field
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_BEQ     = 6'h04;
localparam logic [5:0] OPC_BNE     = 6'h05;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_ORI     = 6'h0d;
localparam logic [5:0] OPC_LUI     = 6'h0f;
localparam logic [5:0] OPC_LW      = 6'h23;
localparam logic [5:0] OPC_SW      = 6'h2b;

// funct field of SPECIAL
localparam logic [5:0] FN_MFHI  = 6'h10;
localparam logic [5:0] FN_MFLO  = 6'h12;
localparam logic [5:0] FN_MULTU = 6'h19;
localparam logic [5:0] FN_ADDU  = 6'h21;
localparam logic [5:0] FN_SUBU  = 6'h23;
localparam logic [5:0] FN_AND   = 6'h24;
localparam logic [5:0] FN_OR    = 6'h25;
localparam logic [5:0] FN_XOR   = 6'h26;
localparam logic [5:0] FN_SLT   = 6'h2a;

typedef enum logic [4:0] {
	OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
	OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW, OP_BEQ, OP_BNE,
	OP_MULTU, OP_MFHI, OP_MFLO
} op_t;

// rd is 0 for anything that does not write a register
typedef struct packed {
	op_t       op;
	uint32_t   pc;
	reg_addr_t rd;
	uint32_t   a;
	uint32_t   b;
	uint32_t   imm;
	logic      is_load;
	logic      is_store;
	logic      is_branch;
	logic      valid;
} decoded_t;

typedef struct packed {
	reg_addr_t rd;
	uint32_t   wdata;
	logic      is_load;
	uint32_t   addr;
	uint32_t   sdata;
	logic      valid;
} exec_t;

typedef enum logic [1:0] {
	MUL_IDLE, MUL_RUN, MUL_DONE
} mul_state_t;

endpackage

// ==== cpu_top.sv ====
module cpu_top #(
	parameter bus_pkg::phys_addr_t RESET_PC  = '0,
	parameter int                  MUL_STEPS = 8
) (
	input  logic                clk,
	input  logic                rst,

	output logic                imem_read_o,
	output bus_pkg::phys_addr_t imem_addr_o,
	input  bus_pkg::bus_word_t  imem_rdata_i,
	input  logic                imem_stall_i,

	output logic                dmem_read_o,
	output logic                dmem_write_o,
	output bus_pkg::phys_addr_t dmem_addr_o,
	output bus_pkg::bus_word_t  dmem_wdata_o,
	input  bus_pkg::bus_word_t  dmem_rdata_i,
	input  logic                dmem_stall_i
);

cpu_ibus_if ibus();
cpu_dbus_if dbus();

assign imem_read_o = ibus.read;
assign imem_addr_o = ibus.address;
assign ibus.rddata = imem_rdata_i;
assign ibus.stall  = imem_stall_i;

assign dmem_read_o  = dbus.read;
assign dmem_write_o = dbus.write;
assign dmem_addr_o  = dbus.address;
assign dmem_wdata_o = dbus.wrdata;
assign dbus.rddata  = dmem_rdata_i;
assign dbus.stall   = dmem_stall_i;

cpu_core #(
	.RESET_PC  ( RESET_PC  ),
	.MUL_STEPS ( MUL_STEPS )
) core_inst (
	.clk,
	.rst,
	.ibus ( ibus.master ),
	.dbus ( dbus.master )
);

endmodule

// ==== flist.f ====
bus_pkg.sv
cpu_pkg.sv
cpu_bus_if.sv
regfile.sv
instr_decode.sv
instr_exec.sv
multi_cycle_exec.sv
cpu_core.sv
cpu_top.sv
tb_cpu_top.sv

// ==== instr_decode.sv ====
module instr_decode (
	input  cpu_pkg::uint32_t         instr_i,
	input  cpu_pkg::uint32_t         pc_i,
	input  logic                     valid_i,
	output cpu_pkg::reg_addr_t [1:0] reg_raddr_o,
	input  cpu_pkg::uint32_t   [1:0] reg_rdata_i,
	input  cpu_pkg::exec_t           fwd_exec_i,
	input  cpu_pkg::exec_t           fwd_wb_i,
	output cpu_pkg::decoded_t        decoded_o,
	output logic                     load_use_o
);

logic [5:0]         opcode;
logic [5:0]         funct;
cpu_pkg::reg_addr_t rs_addr;
cpu_pkg::reg_addr_t rt_addr;
cpu_pkg::reg_addr_t rd_addr;
cpu_pkg::uint32_t   imm_sext;

assign opcode   = instr_i[31:26];
assign funct    = instr_i[5:0];
assign rs_addr  = instr_i[25:21];
assign rt_addr  = instr_i[20:16];
assign rd_addr  = instr_i[15:11];
assign imm_sext = {{16{instr_i[15]}}, instr_i[15:0]};

assign reg_raddr_o[0] = rs_addr;
assign reg_raddr_o[1] = rt_addr;

// youngest producer wins
function automatic cpu_pkg::uint32_t forward_operand(
	input cpu_pkg::reg_addr_t ra,
	input cpu_pkg::uint32_t   rf_value,
	input cpu_pkg::exec_t     ex,
	input cpu_pkg::exec_t     wb
);
	if (ex.valid && ex.rd != '0 && ex.rd == ra)
		return ex.wdata;
	if (wb.valid && wb.rd != '0 && wb.rd == ra)
		return wb.wdata;
	return rf_value;
endfunction

always_comb begin
	decoded_o       = '0;
	decoded_o.pc    = pc_i;
	decoded_o.valid = valid_i;
	decoded_o.a     = forward_operand(rs_addr, reg_rdata_i[0], fwd_exec_i, fwd_wb_i);
	decoded_o.b     = forward_operand(rt_addr, reg_rdata_i[1], fwd_exec_i, fwd_wb_i);
	decoded_o.imm   = imm_sext;
	decoded_o.op    = cpu_pkg::OP_NOP;

	case (opcode)
		cpu_pkg::OPC_SPECIAL: begin
			case (funct)
				cpu_pkg::FN_ADDU:  decoded_o.op = cpu_pkg::OP_ADDU;
				cpu_pkg::FN_SUBU:  decoded_o.op = cpu_pkg::OP_SUBU;
				cpu_pkg::FN_AND:   decoded_o.op = cpu_pkg::OP_AND;
				cpu_pkg::FN_OR:    decoded_o.op = cpu_pkg::OP_OR;
				cpu_pkg::FN_XOR:   decoded_o.op = cpu_pkg::OP_XOR;
				cpu_pkg::FN_SLT:   decoded_o.op = cpu_pkg::OP_SLT;
				cpu_pkg::FN_MULTU: decoded_o.op = cpu_pkg::OP_MULTU;
				cpu_pkg::FN_MFHI:  decoded_o.op = cpu_pkg::OP_MFHI;
				cpu_pkg::FN_MFLO:  decoded_o.op = cpu_pkg::OP_MFLO;
				default:           decoded_o.op = cpu_pkg::OP_NOP;
			endcase
		end
		cpu_pkg::OPC_ADDIU: decoded_o.op = cpu_pkg::OP_ADDIU;
		cpu_pkg::OPC_ORI:   decoded_o.op = cpu_pkg::OP_ORI;
		cpu_pkg::OPC_LUI:   decoded_o.op = cpu_pkg::OP_LUI;
		cpu_pkg::OPC_LW:    decoded_o.op = cpu_pkg::OP_LW;
		cpu_pkg::OPC_SW:    decoded_o.op = cpu_pkg::OP_SW;
		cpu_pkg::OPC_BEQ:   decoded_o.op = cpu_pkg::OP_BEQ;
		cpu_pkg::OPC_BNE:   decoded_o.op = cpu_pkg::OP_BNE;
		default:            decoded_o.op = cpu_pkg::OP_NOP;
	endcase

	case (decoded_o.op)
		cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
		cpu_pkg::OP_XOR, cpu_pkg::OP_SLT, cpu_pkg::OP_MFHI, cpu_pkg::OP_MFLO:
			decoded_o.rd = rd_addr;
		cpu_pkg::OP_ADDIU, cpu_pkg::OP_LW:
			decoded_o.rd = rt_addr;
		cpu_pkg::OP_ORI: begin
			decoded_o.rd  = rt_addr;
			decoded_o.imm = {16'b0, instr_i[15:0]};
		end
		cpu_pkg::OP_LUI: begin
			decoded_o.rd  = rt_addr;
			decoded_o.imm = {instr_i[15:0], 16'b0};
		end
		// word offset
		cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
			decoded_o.imm = {imm_sext[29:0], 2'b00};
		default:
			decoded_o.rd = '0;
	endcase

	decoded_o.is_load   = decoded_o.op == cpu_pkg::OP_LW;
	decoded_o.is_store  = decoded_o.op == cpu_pkg::OP_SW;
	decoded_o.is_branch = decoded_o.op == cpu_pkg::OP_BEQ || decoded_o.op == cpu_pkg::OP_BNE;
end

// load data only shows up in MEM, one cycle too late for EX forwarding
assign load_use_o = valid_i && fwd_exec_i.valid && fwd_exec_i.is_load
	&& fwd_exec_i.rd != '0
	&& (fwd_exec_i.rd == rs_addr || fwd_exec_i.rd == rt_addr);

endmodule

// ==== instr_exec.sv ====
module instr_exec (
	input  cpu_pkg::decoded_t data_i,
	input  cpu_pkg::uint64_t  hilo_i,
	output cpu_pkg::exec_t    result_o,
	output logic              branch_taken_o,
	output cpu_pkg::uint32_t  branch_target_o
);

cpu_pkg::uint32_t sum_imm;
logic             operands_equal;

assign sum_imm        = data_i.a + data_i.imm;
assign operands_equal = data_i.a == data_i.b;

// offset counts from the delay slot
assign branch_target_o = data_i.pc + 32'd4 + data_i.imm;
assign branch_taken_o  = data_i.valid && data_i.is_branch
	&& (data_i.op == cpu_pkg::OP_BEQ ? operands_equal : !operands_equal);

always_comb begin
	result_o         = '0;
	result_o.rd      = data_i.rd;
	result_o.is_load = data_i.is_load;
	result_o.addr    = sum_imm;
	result_o.sdata   = data_i.b;
	result_o.valid   = data_i.valid;

	case (data_i.op)
		cpu_pkg::OP_ADDU:  result_o.wdata = data_i.a + data_i.b;
		cpu_pkg::OP_SUBU:  result_o.wdata = data_i.a - data_i.b;
		cpu_pkg::OP_AND:   result_o.wdata = data_i.a & data_i.b;
		cpu_pkg::OP_OR:    result_o.wdata = data_i.a | data_i.b;
		cpu_pkg::OP_XOR:   result_o.wdata = data_i.a ^ data_i.b;
		cpu_pkg::OP_SLT:
			result_o.wdata = {31'b0, $signed(data_i.a) < $signed(data_i.b)};
		cpu_pkg::OP_ADDIU: result_o.wdata = sum_imm;
		cpu_pkg::OP_ORI:   result_o.wdata = data_i.a | data_i.imm;
		// decode already moved the immediate to the upper half
		cpu_pkg::OP_LUI:   result_o.wdata = data_i.imm;
		cpu_pkg::OP_MFHI:  result_o.wdata = hilo_i[63:32];
		cpu_pkg::OP_MFLO:  result_o.wdata = hilo_i[31:0];
		default:           result_o.wdata = '0;
	endcase
end

endmodule

// ==== multi_cycle_exec.sv ====
module multi_cycle_exec #(
	parameter int MUL_STEPS = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start_i,
	input  cpu_pkg::uint32_t a_i,
	input  cpu_pkg::uint32_t b_i,
	output logic             stall_o,
	output cpu_pkg::uint64_t hilo_o
);

localparam int BITS = 32 / MUL_STEPS;

cpu_pkg::mul_state_t state_q;
cpu_pkg::uint32_t    mcand_q;
cpu_pkg::uint64_t    hilo_q;
logic [5:0]          step_q;

// add mcand times the low BITS multiplier bits into HI, then shift the pair right
function automatic cpu_pkg::uint64_t mul_step(
	input cpu_pkg::uint64_t prod,
	input cpu_pkg::uint32_t mcand
);
	logic [31+BITS:0] sum;
	logic [63+BITS:0] wide;
	sum  = prod[63:32] + mcand * prod[BITS-1:0];
	wide = {sum, prod[31:0]};
	return wide[63+BITS:BITS];
endfunction

always_ff @(posedge clk) begin
	if (rst) begin
		state_q <= cpu_pkg::MUL_IDLE;
		step_q  <= '0;
		hilo_q  <= '0;
	end else begin
		case (state_q)
			cpu_pkg::MUL_IDLE: begin
				// first step straight from the operands
				if (start_i) begin
					hilo_q  <= mul_step({32'b0, b_i}, a_i);
					step_q  <= 6'd1;
					state_q <= (MUL_STEPS == 1) ? cpu_pkg::MUL_DONE : cpu_pkg::MUL_RUN;
				end
			end
			cpu_pkg::MUL_RUN: begin
				hilo_q <= mul_step(hilo_q, mcand_q);
				step_q <= step_q + 6'd1;
				if (step_q == MUL_STEPS - 1)
					state_q <= cpu_pkg::MUL_DONE;
			end
			default: state_q <= cpu_pkg::MUL_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state_q == cpu_pkg::MUL_IDLE && start_i)
		mcand_q <= a_i;
end

assign stall_o = (state_q == cpu_pkg::MUL_IDLE && start_i) || state_q == cpu_pkg::MUL_RUN;
assign hilo_o  = hilo_q;

// the core only starts on the first EX cycle of a MULTU
a_no_restart: assert property (@(posedge clk) disable iff (rst)
	state_q == cpu_pkg::MUL_RUN |-> !start_i);

endmodule

// ==== regfile.sv ====
module regfile (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_pkg::reg_addr_t [1:0] raddr_i,
	output cpu_pkg::uint32_t   [1:0] rdata_o,
	input  logic                     we_i,
	input  cpu_pkg::reg_addr_t       waddr_i,
	input  cpu_pkg::uint32_t         wdata_i
);

cpu_pkg::uint32_t regs [32];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < 32; i++) begin
			regs[i] <= '0;
		end
	end else if (we_i && waddr_i != '0) begin
		regs[waddr_i] <= wdata_i;
	end
end

for (genvar i = 0; i < 2; i++) begin : g_read
	assign rdata_o[i] = regs[raddr_i[i]];

	// r0 is never written, so it keeps its reset value
	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		raddr_i[i] == '0 |-> rdata_o[i] == '0);
end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_cpu_top -o sim || exit 1
out="$(./obj_dir/sim)"
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// ==== tb_cpu_top.sv ====
module tb_cpu_top;

localparam int TIMEOUT = 20000;
localparam logic [5:0] OP_SPECIAL = 6'h00, OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_ADDIU = 6'h09;
localparam logic [5:0] OP_ORI = 6'h0d, OP_LUI = 6'h0f, OP_LW = 6'h23, OP_SW = 6'h2b;
localparam logic [5:0] FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25;
localparam logic [5:0] FN_XOR = 6'h26, FN_SLT = 6'h2a, FN_MULTU = 6'h19;
localparam logic [5:0] FN_MFHI = 6'h10, FN_MFLO = 6'h12;

logic clk, rst;
logic imem_read, imem_stall, dmem_read, dmem_write, dmem_stall;
logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
logic stall_en;
logic [31:0] imem [1024];
logic [31:0] dmem [256];
logic [31:0] prog [$];
logic [31:0] act_addr [$], act_data [$], exp_addr [$], exp_data [$];
logic [31:0] m_regs [32];
logic [31:0] m_mem [256];
logic [31:0] m_hi, m_lo;
logic [4:0]  last_rd;
int tests_run, tests_failed;

cpu_top #(.RESET_PC(32'h0), .MUL_STEPS(8)) i_dut (
	.clk, .rst,
	.imem_read_o(imem_read), .imem_addr_o(imem_addr),
	.imem_rdata_i(imem_rdata), .imem_stall_i(imem_stall),
	.dmem_read_o(dmem_read), .dmem_write_o(dmem_write), .dmem_addr_o(dmem_addr),
	.dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata), .dmem_stall_i(dmem_stall)
);

always #4 clk = ~clk;

// synchronous SRAM style memories, stall sampled together with the request
always @(posedge clk) begin
	imem_stall <= !rst && stall_en && ($urandom % 4 == 0);
	dmem_stall <= !rst && stall_en && ($urandom % 3 == 0);
	if (imem_read && !imem_stall)
		imem_rdata <= imem[imem_addr[11:2]];
	if (dmem_write && !dmem_stall) begin
		dmem[dmem_addr[9:2]] <= dmem_wdata;
		act_addr.push_back(dmem_addr);
		act_data.push_back(dmem_wdata);
	end else if (dmem_read && !dmem_stall) begin
		dmem_rdata <= dmem[dmem_addr[9:2]];
	end
end

function automatic logic [31:0] dmem_fill(input logic [31:0] addr);
	return (addr * 32'h0100_0193) ^ 32'hc3a5_0f1e;
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
	return {OP_SPECIAL, rs, rt, rd, 5'h00, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] opc, input logic [4:0] rs, rt,
	input logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

function automatic logic [4:0] rand_reg();
	return 5'($urandom % 15 + 1);
endfunction

// half of the time the source is the previous destination
task automatic add_alu();
	logic [4:0] rs, rd;
	logic [5:0] fns [6];
	int k;
	fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT};
	rs = ($urandom % 2 == 0) ? last_rd : rand_reg();
	rd = rand_reg();
	k = int'($urandom % 9);
	if (k < 6)
		prog.push_back(enc_r(rs, rand_reg(), rd, fns[k]));
	else if (k == 6)
		prog.push_back(enc_i(OP_ADDIU, rs, rd, 16'($urandom)));
	else if (k == 7)
		prog.push_back(enc_i(OP_ORI, rs, rd, 16'($urandom)));
	else
		prog.push_back(enc_i(OP_LUI, 5'd0, rd, 16'($urandom)));
	last_rd = rd;
endtask

// mode 0 alu, 1 load and store, 2 branches, 3 multiply
task automatic gen_program(input int mode);
	logic [4:0] rs, rt;
	int k;
	prog.delete();
	last_rd = 5'd1;
	for (int i = 1; i < 16; i++) begin
		prog.push_back(enc_i(OP_LUI, 5'd0, 5'(i), 16'($urandom)));
		prog.push_back(enc_i(OP_ORI, 5'(i), 5'(i), 16'($urandom)));
	end
	for (int n = 0; n < 40; n++) begin
		k = int'($urandom % 3);
		rs = rand_reg();
		rt = ($urandom % 2 == 0) ? rs : rand_reg();
		if (mode == 1 && k == 1) begin
			last_rd = rand_reg();
			prog.push_back(enc_i(OP_LW, 5'd0, last_rd, 16'(32'h100 + 4 * ($urandom % 64))));
			add_alu();
		end else if (mode == 1 && k == 2) begin
			prog.push_back(enc_i(OP_SW, 5'd0, rs, 16'(32'h100 + 4 * ($urandom % 64))));
		end else if (mode == 2 && k == 0) begin
			k = int'($urandom % 4);
			prog.push_back(enc_i(($urandom % 2 == 0) ? OP_BEQ : OP_BNE, rs, rt, 16'(k + 1)));
			add_alu();
			repeat (k) add_alu();
		end else if (mode == 3 && k != 0) begin
			prog.push_back(enc_r(rs, rand_reg(), 5'd0, FN_MULTU));
			prog.push_back(enc_r(5'd0, 5'd0, rand_reg(), FN_MFHI));
			last_rd = rand_reg();
			prog.push_back(enc_r(5'd0, 5'd0, last_rd, FN_MFLO));
		end else begin
			add_alu();
		end
	end
	for (int i = 1; i < 16; i++)
		prog.push_back(enc_i(OP_SW, 5'd0, 5'(i), 16'(32'h200 + 4 * i)));
endtask

task automatic model_exec(input logic [31:0] w);
	logic [4:0]  rs, rt, rd, dst;
	logic [31:0] a, b, simm, res;
	logic [63:0] prod;
	rs = w[25:21];
	rt = w[20:16];
	rd = w[15:11];
	a = m_regs[rs];
	b = m_regs[rt];
	simm = {{16{w[15]}}, w[15:0]};
	res = '0;
	dst = '0;
	case (w[31:26])
		OP_SPECIAL: begin
			dst = rd;
			case (w[5:0])
				FN_ADDU: res = a + b;
				FN_SUBU: res = a - b;
				FN_AND:  res = a & b;
				FN_OR:   res = a | b;
				FN_XOR:  res = a ^ b;
				FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_MFHI: res = m_hi;
				FN_MFLO: res = m_lo;
				FN_MULTU: begin
					prod = {32'h0, a} * {32'h0, b};
					m_hi = prod[63:32];
					m_lo = prod[31:0];
					dst = '0;
				end
				default: dst = '0;
			endcase
		end
		OP_ADDIU: begin
			res = a + simm;
			dst = rt;
		end
		OP_ORI: begin
			res = a | {16'h0, w[15:0]};
			dst = rt;
		end
		OP_LUI: begin
			res = {w[15:0], 16'h0};
			dst = rt;
		end
		OP_LW: begin
			res = m_mem[(a + simm) >> 2 & 32'hff];
			dst = rt;
		end
		OP_SW: begin
			m_mem[(a + simm) >> 2 & 32'hff] = b;
			exp_addr.push_back(a + simm);
			exp_data.push_back(b);
		end
		default: dst = '0;
	endcase
	if (dst != 5'd0)
		m_regs[dst] = res;
endtask

// delay slot runs before the branch takes effect
task automatic run_model();
	int pc;
	logic taken;
	exp_addr.delete();
	exp_data.delete();
	for (int i = 0; i < 32; i++)
		m_regs[i] = '0;
	for (int i = 0; i < 256; i++)
		m_mem[i] = dmem_fill(32'(i * 4));
	pc = 0;
	while (pc < prog.size()) begin
		if (prog[pc][31:26] == OP_BEQ || prog[pc][31:26] == OP_BNE) begin
			taken = (m_regs[prog[pc][25:21]] == m_regs[prog[pc][20:16]]) ==
				(prog[pc][31:26] == OP_BEQ);
			model_exec(prog[pc + 1]);
			pc = taken ? pc + 1 + int'($signed(prog[pc][15:0])) : pc + 2;
		end else begin
			model_exec(prog[pc]);
			pc++;
		end
	end
endtask

task automatic check_reset();
	int cycles;
	int errs;
	errs = 0;
	@(negedge clk);
	if (imem_read || dmem_read || dmem_write) begin
		$display("reset: bus strobes are not low during reset");
		errs++;
	end
	@(posedge clk) rst <= 1'b0;
	cycles = 0;
	@(negedge clk);
	while (!imem_read && cycles < TIMEOUT) begin
		@(negedge clk);
		cycles++;
	end
	if (!imem_read) begin
		$display("reset: no instruction fetch appeared after reset");
		errs++;
	end else if (imem_addr != 32'h0) begin
		$display("Error reset: expected first fetch %h, actual %h", 32'h0, imem_addr);
		errs++;
	end
	tests_run++;
	if (errs != 0)
		tests_failed++;
	$display("test reset: %s", (errs == 0) ? "ok" : "failed");
endtask

task automatic run_program(input string name, input logic stall);
	int cycles;
	int errs;
	errs = 0;
	@(posedge clk);
	rst <= 1'b1;
	stall_en <= 1'b0;
	@(negedge clk);
	for (int i = 0; i < 1024; i++)
		imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
	for (int i = 0; i < 256; i++)
		dmem[i] = dmem_fill(32'(i * 4));
	act_addr.delete();
	act_data.delete();
	run_model();
	@(posedge clk);
	@(posedge clk);
	rst <= 1'b0;
	stall_en <= stall;
	cycles = 0;
	while (act_addr.size() < exp_addr.size() && cycles < TIMEOUT) begin
		@(negedge clk);
		cycles++;
	end
	if (act_addr.size() < exp_addr.size()) begin
		$display("%s: core stopped writing after %0d of %0d writes", name,
			act_addr.size(), exp_addr.size());
		errs++;
	end
	for (int i = 0; i < act_addr.size() && i < exp_addr.size(); i++) begin
		if (act_addr[i] != exp_addr[i] || act_data[i] != exp_data[i]) begin
			$display("Error %s: write %0d expected addr %h data %h, actual addr %h data %h",
				name, i, exp_addr[i], exp_data[i], act_addr[i], act_data[i]);
			errs++;
		end
	end
	tests_run++;
	if (errs != 0)
		tests_failed++;
	$display("test %s: %s, %0d writes", name, (errs == 0) ? "ok" : "failed", exp_addr.size());
endtask

initial begin
	clk = 1'b0;
	rst = 1'b1;
	stall_en = 1'b0;
	imem_stall = 1'b0;
	dmem_stall = 1'b0;
	imem_rdata = '0;
	dmem_rdata = '0;
	tests_run = 0;
	tests_failed = 0;
	void'($urandom(46));
	for (int i = 0; i < 1024; i++)
		imem[i] = '0;
	check_reset();
	gen_program(0);
	run_program("alu_forwarding", 1'b0);
	run_program("alu_forwarding_stall", 1'b1);
	gen_program(1);
	run_program("load_store", 1'b0);
	gen_program(2);
	run_program("branch_delay_slot", 1'b0);
	gen_program(3);
	run_program("multiply_hilo", 1'b0);
	$display("%0d tests, %0d passed, %0d failed", tests_run,
		tests_run - tests_failed, tests_failed);
	if (tests_failed == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

endmodule
